/* flist.f */
+incdir+src
src/vid_pkg.sv
src/axis_pkg.sv
src/raster_counter.sv
src/pattern_gen.sv
src/axis_stream_master.sv
src/video_source_top.sv
tb/tb_video_source.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_video_source -o sim_tb \
	|| { echo "Build failed"; exit 1; }

output="$(./obj_dir/sim_tb 2>&1)"
echo "$output"

echo "$output" | grep -q "All tests passed" \
	&& { echo "Simulation PASSED"; exit 0; } \
	|| { echo "Simulation FAILED"; exit 1; }

/* src/axis_pkg.sv */
`default_nettype none

package axis_pkg;

	// Video sideband carried next to each pixel
	typedef struct packed {
		logic last; // End of line
		logic user; // Start of frame
	} axis_side_t;

	// Registered beat between pattern_gen and the stream master
	typedef struct packed {
		vid_pkg::rgb_t pixel; // Pixel value
		axis_side_t    side;  // Sideband for this pixel
		logic          valid; // Beat holds a pixel
	} pix_beat_t;

endpackage

`default_nettype wire

/* src/axis_stream_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_stream_master #(
	parameter type payload_t = vid_pkg::rgb_t // Beat payload
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire payload_t        in_data,       // Payload of incoming beat
	input  wire axis_pkg::axis_side_t in_side,  // Sideband of incoming beat
	input  wire                  in_valid,      // Incoming beat present
	input  wire                  m_axis_tready, // Sink ready
	output payload_t             m_axis_tdata,  // Held payload
	output logic                 m_axis_tvalid, // Beat held
	output logic                 m_axis_tlast,  // End of line
	output logic                 m_axis_tuser,  // Start of frame
	output logic                 stall          // Full and blocked
);

	typedef enum logic {
		IDLE, // Register empty
		SEND  // Register holds a beat
	} state_t;

	state_t               state;
	state_t               next_state;
	payload_t             data_q; // Held payload
	axis_pkg::axis_side_t side_q; // Held sideband
	logic                 take;   // Capture incoming beat

	// Upstream freezes on this, so nothing is ever dropped
	assign stall = (state == SEND) && !m_axis_tready;

	// Empty, or held beat leaves this cycle
	assign take = in_valid && !stall;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (take) begin
					next_state = SEND;
				end
			end
			SEND: begin
				if (m_axis_tready && !take) begin
					next_state = IDLE; // Drained with nothing behind it
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_q <= '0;
			side_q <= '0;
		end else if (take) begin
			data_q <= in_data;
			side_q <= in_side;
		end
	end

	always_comb begin
		m_axis_tvalid = (state == SEND);
		m_axis_tdata  = data_q;                         // Stable while SEND
		m_axis_tlast  = m_axis_tvalid && side_q.last;  // Qualified by tvalid
		m_axis_tuser  = m_axis_tvalid && side_q.user;
	end

endmodule

`default_nettype wire

/* src/pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module pattern_gen #(
	parameter int H_ACTIVE = `VID_H_ACTIVE // Pixels per line
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  start,       // Frame request
	input  wire vid_pkg::pattern_t pattern_sel, // Pattern for next frame
	input  wire vid_pkg::rgb_t   solid_color, // Color for PAT_SOLID
	input  wire vid_pkg::pix_pos_t pos,       // Position from raster counter
	input  wire axis_pkg::axis_side_t side,   // Sideband for pos
	input  wire                  pos_valid,   // pos is live
	input  wire                  stall,       // Hold beat
	output axis_pkg::pix_beat_t  beat         // Registered pixel beat
);

	localparam int COMP_W = `VID_COMP_W;
	localparam int BAR_W  = (H_ACTIVE >= 8) ? (H_ACTIVE / 8) : 1; // Bar width in pixels

	vid_pkg::pattern_t    pat_q;   // Pattern for this frame
	vid_pkg::rgb_t        solid_q; // Solid color for this frame
	vid_pkg::rgb_t        pixel;   // Pixel for current pos
	logic [15:0]          bar_idx; // Which color bar
	logic [COMP_W-1:0]    ramp_v;  // Gray level for ramp
	logic                 check_v; // Checker cell is white

	// Settings only change between frames
	// An accepted start always falls in a cycle with no live position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pat_q <= vid_pkg::PAT_BARS;
		end else if (start && !pos_valid) begin
			pat_q <= pattern_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (start && !pos_valid) begin
			solid_q <= solid_color;
		end
	end

	always_comb begin
		bar_idx = pos.x / 16'(BAR_W);
		ramp_v  = COMP_W'({pos.x[7:0], 4'b0000}); // x times 16, wraps
		check_v = pos.x[`VID_CHECK_SHIFT] ^ pos.y[`VID_CHECK_SHIFT];
		pixel   = '0;
		case (pat_q)
			vid_pkg::PAT_BARS: begin
				// White yellow cyan green magenta red blue black
				if (bar_idx < 16'd8) begin
					pixel.r = {COMP_W{~bar_idx[1]}};
					pixel.g = {COMP_W{~bar_idx[2]}};
					pixel.b = {COMP_W{~bar_idx[0]}};
				end
			end
			vid_pkg::PAT_RAMP: begin
				pixel.r = ramp_v;
				pixel.g = ramp_v;
				pixel.b = ramp_v;
			end
			vid_pkg::PAT_CHECKER: begin
				if (check_v) begin
					pixel = '1; // White cell
				end
			end
			vid_pkg::PAT_SOLID: begin
				pixel = solid_q;
			end
			default: begin
				pixel = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat <= '0;
		end else if (!stall) begin
			beat.pixel <= pixel;
			beat.side  <= side;
			beat.valid <= pos_valid; // Bubbles pass through as invalid
		end
	end

endmodule

`default_nettype wire

/* src/raster_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module raster_counter #(
	parameter int H_ACTIVE = `VID_H_ACTIVE, // Pixels per line
	parameter int V_ACTIVE = `VID_V_ACTIVE  // Lines per frame
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  start,     // One-cycle frame request
	input  wire                  stall,     // Downstream blocked, hold position
	output vid_pkg::pix_pos_t    pos,       // Current scan position
	output axis_pkg::axis_side_t side,      // Sideband for pos
	output logic                 pos_valid, // pos is a live pixel
	output logic                 busy       // Frame in progress
);

	localparam logic [15:0] X_LAST = 16'(H_ACTIVE - 1); // Last column
	localparam logic [15:0] Y_LAST = 16'(V_ACTIVE - 1); // Last line

	logic       line_end;  // At last column
	logic       frame_end; // At last pixel of frame
	logic       advance;   // Step position this cycle
	logic       accept;    // Start taken
	logic [1:0] drain;     // Non-stalled cycles until last beat is out

	assign line_end  = (pos.x == X_LAST);
	assign frame_end = line_end && (pos.y == Y_LAST);
	assign advance   = pos_valid && !stall;
	assign accept    = start && !busy;    // Ignore start mid-frame

	// Busy also covers the two stages still holding pixels after the scan
	assign busy = pos_valid || (drain != 2'd0);

	always_comb begin
		side      = '0;
		side.last = line_end;                       // End of each line
		side.user = (pos.x == '0) && (pos.y == '0); // First pixel of frame
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos       <= '0;
			pos_valid <= 1'b0;
			drain     <= 2'd0;
		end else begin
			if (accept) begin
				pos       <= '0;   // Scan starts at (0,0)
				pos_valid <= 1'b1;
			end else if (advance) begin
				if (frame_end) begin
					pos_valid <= 1'b0; // Last position issued
					drain     <= 2'd2; // Pattern stage plus output register
				end else if (line_end) begin
					pos.x <= '0;
					pos.y <= pos.y + 16'd1; // Next line
				end else begin
					pos.x <= pos.x + 16'd1;
				end
			end else if ((drain != 2'd0) && !stall) begin
				drain <= drain - 2'd1; // Pipeline moved one step
			end
		end
	end

endmodule

`default_nettype wire

/* src/vid_params.svh */
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// Default frame geometry
// Kept small so one frame is only a few dozen beats
`define VID_H_ACTIVE 16

`define VID_V_ACTIVE 4

// Bits per color component
`define VID_COMP_W 8

// Checkerboard block side is 2**VID_CHECK_SHIFT pixels
`define VID_CHECK_SHIFT 2

`endif

/* src/vid_pkg.sv */
`default_nettype none

`include "vid_params.svh"

package vid_pkg;

	// Pixel payload
	typedef struct packed {
		logic [`VID_COMP_W-1:0] r; // Red component
		logic [`VID_COMP_W-1:0] g; // Green component
		logic [`VID_COMP_W-1:0] b; // Blue component
	} rgb_t;

	// Raster position, origin at top left
	typedef struct packed {
		logic [15:0] x; // Column
		logic [15:0] y; // Line
	} pix_pos_t;

	// Pattern select
	typedef enum logic [1:0] {
		PAT_BARS    = 2'd0, // Eight vertical color bars
		PAT_RAMP    = 2'd1, // Horizontal gray ramp
		PAT_CHECKER = 2'd2, // Black and white blocks
		PAT_SOLID   = 2'd3  // Latched solid color
	} pattern_t;

endpackage

`default_nettype wire

/* src/video_source_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module video_source_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,         // One-cycle frame request
	input  wire vid_pkg::pattern_t pattern_sel,   // Pattern select level
	input  wire vid_pkg::rgb_t     solid_color,   // Color for PAT_SOLID
	input  wire                    m_axis_tready, // Sink ready
	output vid_pkg::rgb_t          m_axis_tdata,  // Pixel out
	output logic                   m_axis_tvalid, // Pixel valid
	output logic                   m_axis_tlast,  // End of line
	output logic                   m_axis_tuser,  // Start of frame
	output logic                   busy           // Frame in progress
);

	vid_pkg::pix_pos_t    pos;       // Scan position
	axis_pkg::axis_side_t side;      // Sideband for pos
	logic                 pos_valid; // Position live
	logic                 scan_busy; // Counter busy
	logic                 stall;     // Output blocked
	axis_pkg::pix_beat_t  beat;      // Pattern stage output

	raster_counter #(
		.H_ACTIVE(`VID_H_ACTIVE),
		.V_ACTIVE(`VID_V_ACTIVE)
	) raster_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.stall    (stall),
		.pos      (pos),
		.side     (side),
		.pos_valid(pos_valid),
		.busy     (scan_busy)
	);

	pattern_gen #(
		.H_ACTIVE(`VID_H_ACTIVE)
	) pattern_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.pattern_sel(pattern_sel),
		.solid_color(solid_color),
		.pos        (pos),
		.side       (side),
		.pos_valid  (pos_valid),
		.stall      (stall),
		.beat       (beat)
	);

	axis_stream_master #(
		.payload_t(vid_pkg::rgb_t)
	) master_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_data      (beat.pixel),
		.in_side      (beat.side),
		.in_valid     (beat.valid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tdata (m_axis_tdata),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tlast (m_axis_tlast),
		.m_axis_tuser (m_axis_tuser),
		.stall        (stall)
	);

	assign busy = scan_busy | m_axis_tvalid; // Until last beat accepted

endmodule

`default_nettype wire

/* tb/tb_video_source.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module tb_video_source;

	localparam int H_ACTIVE     = `VID_H_ACTIVE;
	localparam int V_ACTIVE     = `VID_V_ACTIVE;
	localparam int FRAME_BEATS  = H_ACTIVE * V_ACTIVE;
	localparam int N_ROWS       = 6;
	localparam int CLK_PERIOD   = 4;                              // ns
	localparam int WATCHDOG_CYC = N_ROWS * FRAME_BEATS * 4 + 200; // Generous for 70% back-pressure

	typedef struct packed {
		vid_pkg::pattern_t pat;     // Pattern for the frame
		vid_pkg::rgb_t     color;   // Solid color
		logic [7:0]        low_pct; // Chance of tready low, percent
	} row_t;

	localparam row_t ROWS [N_ROWS] = '{
		'{vid_pkg::PAT_BARS,    24'h000000, 8'd0},
		'{vid_pkg::PAT_RAMP,    24'h000000, 8'd30},
		'{vid_pkg::PAT_CHECKER, 24'h000000, 8'd70},
		'{vid_pkg::PAT_SOLID,   24'h1f80c4, 8'd0},
		'{vid_pkg::PAT_SOLID,   24'he04a17, 8'd30},
		'{vid_pkg::PAT_BARS,    24'h000000, 8'd70}
	};

	// White yellow cyan green magenta red blue black, as {r,g,b} on flags
	localparam logic [2:0] BAR_RGB [8] = '{
		3'b111, 3'b110, 3'b011, 3'b010, 3'b101, 3'b100, 3'b001, 3'b000
	};

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 start;
	vid_pkg::pattern_t    pattern_sel;
	vid_pkg::rgb_t        solid_color;
	logic                 m_axis_tready = 1'b1;
	vid_pkg::rgb_t        m_axis_tdata;
	logic                 m_axis_tvalid;
	logic                 m_axis_tlast;
	logic                 m_axis_tuser;
	logic                 busy;
	axis_pkg::axis_side_t out_side;      // Observed tlast/tuser

	vid_pkg::pattern_t    cur_pat   = vid_pkg::PAT_BARS; // Row under test
	vid_pkg::rgb_t        cur_color = '0;
	int                   cur_pct   = 0;
	int                   start_cyc = -100; // Edge that sampled the last real start
	logic                 mon_on    = 1'b0;
	int                   error_count = 0;

	int                   cyc = 0;           // Rising edges so far
	logic                 exp_busy = 1'b0;   // Frame expected in flight
	logic                 busy_q = 1'b0;     // busy at the previous sample
	int                   beat_count = 0;    // Beats in current frame
	int                   total_beats = 0;   // Beats over the whole run
	int                   frames_done = 0;
	int                   exp_x = 0;         // Model raster position
	int                   exp_y = 0;
	logic                 hold_pending = 1'b0; // Beat was blocked last cycle
	vid_pkg::rgb_t        held_pixel;
	axis_pkg::axis_side_t held_side;
	axis_pkg::axis_side_t exp_side;

	assign out_side = {m_axis_tlast, m_axis_tuser}; // last is the upper field

	video_source_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.pattern_sel  (pattern_sel),
		.solid_color  (solid_color),
		.m_axis_tready(m_axis_tready),
		.m_axis_tdata (m_axis_tdata),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tlast (m_axis_tlast),
		.m_axis_tuser (m_axis_tuser),
		.busy         (busy)
	);

	always #2 clk = ~clk; // 4 ns period

	// Edge counter and a fresh tready draw every cycle
	always @(posedge clk) begin
		cyc           <= cyc + 1;
		m_axis_tready <= (int'($urandom % 100) >= cur_pct);
	end

	task automatic stop_on_error();
		error_count++;
		$display("Some tests failed");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic check_pixel(input vid_pkg::rgb_t got, input vid_pkg::rgb_t exp,
			input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_side(input axis_pkg::axis_side_t got,
			input axis_pkg::axis_side_t exp, input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// Expected pixel straight from the pattern rules
	function automatic vid_pkg::rgb_t model_pixel(input int x, input int y,
			input vid_pkg::pattern_t pat, input vid_pkg::rgb_t color);
		vid_pkg::rgb_t px;
		logic [2:0]    on;
		int            bar;
		int            level;
		px = '0;
		case (pat)
			vid_pkg::PAT_BARS: begin
				bar  = x / (H_ACTIVE / 8);
				on   = BAR_RGB[bar[2:0]];
				px.r = {`VID_COMP_W{on[2]}};
				px.g = {`VID_COMP_W{on[1]}};
				px.b = {`VID_COMP_W{on[0]}};
			end
			vid_pkg::PAT_RAMP: begin
				level = ((x % 256) * 16) % 256; // Gray step of 16 per column
				px.r  = level[`VID_COMP_W-1:0];
				px.g  = level[`VID_COMP_W-1:0];
				px.b  = level[`VID_COMP_W-1:0];
			end
			vid_pkg::PAT_CHECKER: begin
				if ((((x >> `VID_CHECK_SHIFT) ^ (y >> `VID_CHECK_SHIFT)) & 1) == 1) begin
					px = '1;
				end
			end
			default: begin
				px = color; // Solid
			end
		endcase
		return px;
	endfunction

	// Monitor samples mid-cycle, where every DUT output is settled
	always @(negedge clk) begin
		if (mon_on) begin
			if (cyc == start_cyc) begin
				exp_busy   = 1'b1; // Start was sampled on the last edge
				beat_count = 0;
				exp_x      = 0;
				exp_y      = 0;
			end
			if (hold_pending) begin
				check_flag(m_axis_tvalid, 1'b1, "m_axis_tvalid held");
				check_pixel(m_axis_tdata, held_pixel, "m_axis_tdata held");
				check_side(out_side, held_side, "m_axis_tlast/tuser held");
			end
			if (busy_q && !busy) begin
				check_count(beat_count, FRAME_BEATS, "beats per frame"); // DUT closed the frame
			end
			check_flag(busy, exp_busy, "busy");
			if (!exp_busy) begin
				check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid outside frame");
			end
			if ((cyc >= start_cyc) && (cyc < start_cyc + 2)) begin
				check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid before latency");
			end
			if (cyc == start_cyc + 2) begin
				check_flag(m_axis_tvalid, 1'b1, "m_axis_tvalid at latency");
			end
			if (exp_busy && (cur_pct == 0) && (cyc > start_cyc + 2)) begin
				check_flag(m_axis_tvalid, 1'b1, "m_axis_tvalid gap");
			end
			if (!m_axis_tvalid) begin
				check_side(out_side, '0, "m_axis_tlast/tuser without tvalid");
			end
			hold_pending = m_axis_tvalid && !m_axis_tready;
			held_pixel   = m_axis_tdata;
			held_side    = out_side;
			if (m_axis_tvalid && m_axis_tready) begin // Transfer on the next edge
				if (exp_busy) begin
					check_pixel(m_axis_tdata, model_pixel(exp_x, exp_y, cur_pat, cur_color),
						"m_axis_tdata");
					exp_side.last = (exp_x == H_ACTIVE - 1);
					exp_side.user = (beat_count == 0);
					check_side(out_side, exp_side, "m_axis_tlast/tuser");
				end
				beat_count++;
				total_beats++;
				if (exp_x == H_ACTIVE - 1) begin
					exp_x = 0;
					exp_y++;
				end else begin
					exp_x++;
				end
				if (beat_count == FRAME_BEATS) begin
					exp_busy = 1'b0; // busy falls after this edge
					frames_done++;
				end
			end
			busy_q = busy;
		end
	end

	// One frame plus a start pulse in the middle of it
	task automatic run_frame(input int row);
		@(posedge clk);
		pattern_sel <= cur_pat;
		solid_color <= cur_color;
		start       <= 1'b1;
		@(posedge clk);
		start     <= 1'b0;
		start_cyc = cyc + 1; // This edge samples start
		wait (total_beats >= row * FRAME_BEATS + FRAME_BEATS / 2);
		@(posedge clk);
		start       <= 1'b1; // Must be ignored
		pattern_sel <= (cur_pat == vid_pkg::PAT_RAMP) ? vid_pkg::PAT_BARS : vid_pkg::PAT_RAMP;
		solid_color <= ~cur_color;
		@(posedge clk);
		start <= 1'b0;
		wait (frames_done == row + 1);
		repeat (6) @(posedge clk); // Idle tail, no extra beats allowed
		@(negedge clk);
		check_flag(busy, 1'b0, "busy after frame");
	endtask

	initial begin
		void'($urandom(32'hcc65));
		rst_n       = 1'b0;
		start       = 1'b0;
		pattern_sel = vid_pkg::PAT_BARS;
		solid_color = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid in reset");
		check_side(out_side, '0, "m_axis_tlast/tuser in reset");
		check_flag(busy, 1'b0, "busy in reset");
		@(posedge clk);
		rst_n <= 1'b1; // Third edge ends reset
		mon_on = 1'b1;
		@(negedge clk);
		check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
		check_side(out_side, '0, "m_axis_tlast/tuser after reset");
		check_flag(busy, 1'b0, "busy after reset");
		for (int i = 0; i < N_ROWS; i++) begin
			cur_pat   = ROWS[i].pat;
			cur_color = ROWS[i].color;
			cur_pct   = int'(ROWS[i].low_pct);
			run_frame(i);
		end
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Timeout: the frames did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire
